// ==== common/aes_pkg.sv ====
////////////////////////////////////////////////////////////
// AES field definitions for GF(2^8) under x^8+x^4+x^3+x+1
// Byte type, reduction and affine constants
// Field helpers: xtime, general multiply and inverse
////////////////////////////////////////////////////////////

package aes_pkg;

   // One field element
   typedef logic [7:0] aes_byte_t;

   // Low byte of the reduction polynomial
   localparam aes_byte_t aes_poly = 8'h1b;

   // Constants added after the affine maps
   localparam aes_byte_t aes_affine_c     = 8'h63;
   localparam aes_byte_t aes_inv_affine_c = 8'h05;

   ////////////////////////////////////////////////////////////
   // Field arithmetic
   ////////////////////////////////////////////////////////////

   // Multiply by x, reduce when the top bit falls out
   function automatic aes_byte_t xtime(input aes_byte_t a);
      aes_byte_t shifted;
      shifted = {a[6:0], 1'b0};
      if (a[7]) begin
         shifted = shifted ^ aes_poly;
      end
      return shifted;
   endfunction

   // Shift-and-add multiply over all eight bits of b
   function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
      aes_byte_t acc;
      aes_byte_t term;
      acc  = '0;
      term = a;
      for (int i = 0; i < 8; i++) begin
         // Add the current power of a when b has this bit
         if (b[i]) begin
            acc = acc ^ term;
         end
         term = xtime(term);
      end
      return acc;
   endfunction

   // Inverse as a^254, built from the squares a^2 .. a^128
   // Zero has no inverse and maps to zero
   function automatic aes_byte_t gf_inv(input aes_byte_t a);
      aes_byte_t sq;
      aes_byte_t prod;
      sq   = a;
      prod = 8'h01;
      for (int i = 1; i < 8; i++) begin
         // sq walks through a^(2^i)
         sq   = gf_mul(sq, sq);
         prod = gf_mul(prod, sq);
      end
      return prod;
   endfunction

endpackage

// ==== common/zkn_pkg.sv ====
////////////////////////////////////////////////////////////
// RV32 scalar crypto definitions
// AES32 opcode enum, word and byte-select widths
////////////////////////////////////////////////////////////

package zkn_pkg;

   // Register word width
   localparam int xlen = 32;

   // Byte select field width
   localparam int bs_w = 2;

   // Shift amount is bs scaled by eight
   localparam int shamt_w = bs_w + 3;

   // Opcode bit that marks the decrypt direction
   localparam int op_dec_bit = 1;

   // AES32 word-wise instructions
   // Bit 1 picks the direction, bit 0 adds the column mix
   typedef enum logic [1:0] {
      op_esi  = 2'b00,
      op_esmi = 2'b01,
      op_dsi  = 2'b10,
      op_dsmi = 2'b11
   } aes32_op_e;

endpackage

// ==== aes/aes_sbox.sv ====
////////////////////////////////////////////////////////////
// Forward AES S-box
// Field inverse followed by the forward affine map
////////////////////////////////////////////////////////////

module aes_sbox
   import aes_pkg::*;
(
   input  aes_byte_t in,
   output aes_byte_t out
);

   // Multiplicative inverse of the input
   aes_byte_t inv;

   // Left rotations of the inverse by 1 to 4
   aes_byte_t rot1;
   aes_byte_t rot2;
   aes_byte_t rot3;
   aes_byte_t rot4;

   assign inv = gf_inv(in);

   assign rot1 = {inv[6:0], inv[7]};
   assign rot2 = {inv[5:0], inv[7:6]};
   assign rot3 = {inv[4:0], inv[7:5]};
   assign rot4 = {inv[3:0], inv[7:4]};

   // Affine map, then the constant
   assign out = inv ^ rot1 ^ rot2 ^ rot3 ^ rot4 ^ aes_affine_c;

endmodule

// ==== aes/aes_inv_sbox.sv ====
////////////////////////////////////////////////////////////
// Inverse AES S-box
// Inverse affine map followed by the field inverse
////////////////////////////////////////////////////////////

module aes_inv_sbox
   import aes_pkg::*;
(
   input  aes_byte_t in,
   output aes_byte_t out
);

   // Left rotations of the input by 1, 3 and 6
   aes_byte_t rot1;
   aes_byte_t rot3;
   aes_byte_t rot6;

   // Result of the inverse affine step
   aes_byte_t pre_inv;

   assign rot1 = {in[6:0], in[7]};
   assign rot3 = {in[4:0], in[7:5]};
   assign rot6 = {in[1:0], in[7:2]};

   // Undo the forward affine map first
   assign pre_inv = rot1 ^ rot3 ^ rot6 ^ aes_inv_affine_c;

   // Inverse is its own inverse, so this undoes aes_sbox
   assign out = gf_inv(pre_inv);

endmodule

// ==== aes/mixword.sv ====
////////////////////////////////////////////////////////////
// Forward MixColumns of one 32-bit column
// Byte 0 sits in the low bits
////////////////////////////////////////////////////////////

module mixword
   import aes_pkg::*;
(
   input  logic [31:0] word,
   output logic [31:0] mixed_word
);

   // Column bytes, a0 lowest
   aes_byte_t a0, a1, a2, a3;

   // Products by 2 and by 3
   aes_byte_t x0, x1, x2, x3;

   assign {a3, a2, a1, a0} = word;

   assign x0 = xtime(a0);
   assign x1 = xtime(a1);
   assign x2 = xtime(a2);
   assign x3 = xtime(a3);

   // Rows of the circulant (2 3 1 1); 3a is 2a ^ a
   assign mixed_word[7:0]   = x0 ^ (x1 ^ a1) ^ a2 ^ a3;
   assign mixed_word[15:8]  = a0 ^ x1 ^ (x2 ^ a2) ^ a3;
   assign mixed_word[23:16] = a0 ^ a1 ^ x2 ^ (x3 ^ a3);
   assign mixed_word[31:24] = (x0 ^ a0) ^ a1 ^ a2 ^ x3;

endmodule

// ==== aes/inv_mixword.sv ====
////////////////////////////////////////////////////////////
// Inverse MixColumns of one 32-bit column
// Same byte order as the forward mix
////////////////////////////////////////////////////////////

module inv_mixword
   import aes_pkg::*;
(
   input  logic [31:0] word,
   output logic [31:0] mixed_word
);

   // Column bytes, a0 lowest
   aes_byte_t a0, a1, a2, a3;

   // Row products, one row of the circulant (0e 0b 0d 09) each
   aes_byte_t r0, r1, r2, r3;

   assign {a3, a2, a1, a0} = word;

   assign r0 = gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b)
             ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09);

   assign r1 = gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e)
             ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d);

   assign r2 = gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09)
             ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b);

   assign r3 = gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d)
             ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e);

   // Repack in column order
   assign mixed_word = {r3, r2, r1, r0};

endmodule

// ==== aes/aes32_round.sv ====
////////////////////////////////////////////////////////////
// AES32 round datapath for esi, esmi, dsi and dsmi
// Byte select, substitute, optional mix, rotate, XOR
// Purely combinational
////////////////////////////////////////////////////////////

module aes32_round
   import zkn_pkg::*;
(
   input  aes32_op_e        op,
   input  logic [bs_w-1:0]  bs,
   input  logic [xlen-1:0]  rs1,
   input  logic [xlen-1:0]  rs2,
   output logic [xlen-1:0]  data_out
);

   // Byte offset in bits
   logic [shamt_w-1:0] shamt;

   // rs2 with the selected byte moved down
   logic [xlen-1:0]    sel_word;
   logic [7:0]         sel_byte;

   // Substitution results
   logic [7:0]         fwd_byte;
   logic [7:0]         inv_byte;
   logic [7:0]         sub_byte;

   // Column and mix results
   logic [xlen-1:0]    column;
   logic [xlen-1:0]    fwd_mixed;
   logic [xlen-1:0]    inv_mixed;
   logic [xlen-1:0]    mix_out;

   // Rotate through a doubled word
   logic [2*xlen-1:0]  rot_wide;
   logic [xlen-1:0]    rotated;

   assign shamt    = {bs, 3'b000};
   assign sel_word = rs2 >> shamt;
   assign sel_byte = sel_word[7:0];

   ////////////////////////////////////////////////////////////
   // Substitute and mix
   ////////////////////////////////////////////////////////////

   // Both boxes see the byte, direction bit picks one
   aes_sbox     u_sbox     (.in(sel_byte), .out(fwd_byte));
   aes_inv_sbox u_inv_sbox (.in(sel_byte), .out(inv_byte));

   assign sub_byte = op[op_dec_bit] ? inv_byte : fwd_byte;

   // Substituted byte in the low lane, zeros above
   assign column = {{(xlen-8){1'b0}}, sub_byte};

   mixword     u_mix     (.word(column), .mixed_word(fwd_mixed));
   inv_mixword u_inv_mix (.word(column), .mixed_word(inv_mixed));

   always_comb begin
      case (op)
         op_esmi: mix_out = fwd_mixed;
         op_dsmi: mix_out = inv_mixed;
         // esi and dsi skip the mix
         default: mix_out = column;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Rotate back into place and fold into rs1
   ////////////////////////////////////////////////////////////

   // Upper half holds the rotation; zero shift gives the word itself
   assign rot_wide = {mix_out, mix_out} << shamt;
   assign rotated  = rot_wide[2*xlen-1:xlen];

   assign data_out = rs1 ^ rotated;

endmodule

// ==== design/aes32_unit.sv ====
////////////////////////////////////////////////////////////
// AES32 instruction unit top level
// One register stage after the round datapath
// Result strobe one cycle after each request
////////////////////////////////////////////////////////////

module aes32_unit
   import zkn_pkg::*;
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             op_valid,
   input  aes32_op_e        op,
   input  logic [bs_w-1:0]  bs,
   input  logic [xlen-1:0]  rs1,
   input  logic [xlen-1:0]  rs2,
   output logic [xlen-1:0]  result,
   output logic             result_valid
);

   // Round output, ready in the request cycle
   logic [xlen-1:0] data_out;

   ////////////////////////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////////////////////////

   aes32_round u_round (
      .op       (op),
      .bs       (bs),
      .rs1      (rs1),
      .rs2      (rs2),
      .data_out (data_out)
   );

   ////////////////////////////////////////////////////////////
   // Output stage
   ////////////////////////////////////////////////////////////

   // Capture on request, hold until the next one
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
      end else if (op_valid) begin
         result <= data_out;
      end
   end

   // Strobe follows the request by one cycle
   // No back-pressure, so it never stretches
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result_valid <= 1'b0;
      end else begin
         result_valid <= op_valid;
      end
   end

endmodule

// ==== test/aes32_vectors.svh ====
////////////////////////////////////////////////////////////
// Directed AES32 vectors with hand-derived results
// Substitution in every lane, both mixes, rs1 folding
////////////////////////////////////////////////////////////

`ifndef AES32_VECTORS_SVH
`define AES32_VECTORS_SVH

// Columns are name, op, bs, rs1, rs2 and expected result
task automatic load_vectors();
   // 8'h53 through the forward box gives 8'hed in the chosen lane
   add_vector("esi_53_bs0",    op_esi,  2'd0, 32'h0000_0000, 32'h0000_0053, 32'h0000_00ed);
   add_vector("esi_53_bs1",    op_esi,  2'd1, 32'h0000_0000, 32'h0000_5300, 32'h0000_ed00);
   add_vector("esi_53_bs2",    op_esi,  2'd2, 32'h0000_0000, 32'h0053_0000, 32'h00ed_0000);
   add_vector("esi_53_bs3",    op_esi,  2'd3, 32'h0000_0000, 32'h5300_0000, 32'hed00_0000);
   // Zero has no inverse so only the affine constant remains
   add_vector("esi_zero_bs2",  op_esi,  2'd2, 32'h0000_0000, 32'hff00_a5a5, 32'h0063_0000);
   add_vector("esi_rs1_xor",   op_esi,  2'd0, 32'hdead_beef, 32'h0000_0000, 32'hdead_be8c);

   // With s = 8'hed the column {3s, s, s, 2s} is 32'h2cededc1 before rotation
   add_vector("esmi_53_bs0",   op_esmi, 2'd0, 32'h0000_0000, 32'h0000_0053, 32'h2ced_edc1);
   add_vector("esmi_53_bs1",   op_esmi, 2'd1, 32'h0000_0000, 32'h0000_5300, 32'heded_c12c);
   add_vector("esmi_53_bs2",   op_esmi, 2'd2, 32'h0000_0000, 32'h1153_2233, 32'hedc1_2ced);
   add_vector("esmi_53_bs3",   op_esmi, 2'd3, 32'h0000_0000, 32'h5300_0000, 32'hc12c_eded);
   add_vector("esmi_rs1_ones", op_esmi, 2'd0, 32'hffff_ffff, 32'h0000_0053, 32'hd312_123e);
   // s = 8'h63 gives column 32'ha56363c6
   add_vector("esmi_zero_bs1", op_esmi, 2'd1, 32'h0000_0000, 32'h0000_0000, 32'h6363_c6a5);

   // Inverse box maps 8'hed back to 8'h53 and 8'h63 to zero
   add_vector("dsi_ed_bs0",    op_dsi,  2'd0, 32'h0000_0000, 32'h0000_00ed, 32'h0000_0053);
   add_vector("dsi_63_bs3",    op_dsi,  2'd3, 32'h0000_0000, 32'h6300_0000, 32'h0000_0000);
   add_vector("dsi_rs1_xor",   op_dsi,  2'd1, 32'h1234_5678, 32'h0000_ed00, 32'h1234_0578);
   add_vector("dsi_rs1_pass",  op_dsi,  2'd2, 32'hcafe_f00d, 32'h0063_0000, 32'hcafe_f00d);

   // With s = 8'h53 the column {b.s, d.s, 9.s, e.s} is 32'h5baafd5f before rotation
   add_vector("dsmi_ed_bs0",   op_dsmi, 2'd0, 32'h0000_0000, 32'h0000_00ed, 32'h5baa_fd5f);
   add_vector("dsmi_ed_bs1",   op_dsmi, 2'd1, 32'h0000_0000, 32'h0000_ed00, 32'haafd_5f5b);
   add_vector("dsmi_ed_bs2",   op_dsmi, 2'd2, 32'h0000_0000, 32'h00ed_0000, 32'hfd5f_5baa);
   add_vector("dsmi_ed_bs3",   op_dsmi, 2'd3, 32'h0000_0000, 32'hed00_0000, 32'h5f5b_aafd);
   // Zero column leaves rs1 untouched
   add_vector("dsmi_63_rs1",   op_dsmi, 2'd1, 32'h0bad_f00d, 32'h0000_6300, 32'h0bad_f00d);
endtask

`endif

// ==== test/aes32_unit_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the AES32 unit
// Clock, reset, directed table and seeded random cases
// Reference model built on the FIPS-197 S-box table
// Strobe timing, reset and hold checks
////////////////////////////////////////////////////////////

module aes32_unit_tb
   import zkn_pkg::*;
();

   localparam int n_random = 40;

   // FIPS-197 forward S-box with row 0 in the top bits
   localparam logic [2047:0] sbox_rows = {
      128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
      128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
      128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
      128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
      128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
      128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
      128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
      128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
   };

   logic            clk;
   logic            arst_n;
   logic            op_valid;
   aes32_op_e       op;
   logic [bs_w-1:0] bs;
   logic [xlen-1:0] rs1;
   logic [xlen-1:0] rs2;
   logic [xlen-1:0] result;
   logic            result_valid;

   // Lookup tables for the model
   logic [7:0] sbox_tbl [256];
   logic [7:0] inv_tbl  [256];

   // Directed table rows
   string           vec_name [$];
   aes32_op_e       vec_op   [$];
   logic [bs_w-1:0] vec_bs   [$];
   logic [xlen-1:0] vec_rs1  [$];
   logic [xlen-1:0] vec_rs2  [$];
   logic [xlen-1:0] vec_exp  [$];

   // Requests in flight with the oldest first
   string           pend_name [$];
   logic [xlen-1:0] pend_exp  [$];

   int              seed = 32'h7200_05e9;
   int              passed;
   int              failed;
   int              errors;
   int              limit;
   int              cycles;
   bit              armed;
   logic            prev_valid;
   logic [xlen-1:0] last_result;

   aes32_unit dut_i (
      .clk          (clk),
      .arst_n       (arst_n),
      .op_valid     (op_valid),
      .op           (op),
      .bs           (bs),
      .rs1          (rs1),
      .rs2          (rs2),
      .result       (result),
      .result_valid (result_valid)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   `include "aes32_vectors.svh"

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   // Multiply by a small constant with one doubling per bit of k
   function automatic logic [7:0] field_mul(input logic [7:0] a, input logic [3:0] k);
      logic [7:0] acc;
      logic [7:0] pow;
      acc = 8'h00;
      pow = a;
      for (int i = 0; i < 4; i++) begin
         if (k[i]) begin
            acc = acc ^ pow;
         end
         pow = {pow[6:0], 1'b0} ^ (pow[7] ? 8'h1b : 8'h00);
      end
      return acc;
   endfunction

   function automatic logic [31:0] model_result(input aes32_op_e o, input logic [1:0] b,
                                                input logic [31:0] r1, input logic [31:0] r2);
      logic [7:0]  in_byte;
      logic [7:0]  s;
      logic [31:0] col;
      in_byte = r2[8 * int'(b) +: 8];
      s = (o == op_dsi || o == op_dsmi) ? inv_tbl[in_byte] : sbox_tbl[in_byte];
      case (o)
         op_esmi: col = {field_mul(s, 4'h3), s, s, field_mul(s, 4'h2)};
         op_dsmi: col = {field_mul(s, 4'hb), field_mul(s, 4'hd),
                         field_mul(s, 4'h9), field_mul(s, 4'he)};
         default: col = {24'h000000, s};
      endcase
      // Rotate left one byte per step of bs
      for (int k = 0; k < int'(b); k++) begin
         col = {col[23:0], col[31:24]};
      end
      return r1 ^ col;
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   task automatic add_vector(input string name, input aes32_op_e o, input logic [1:0] b,
                             input logic [31:0] r1, input logic [31:0] r2,
                             input logic [31:0] e);
      vec_name.push_back(name);
      vec_op.push_back(o);
      vec_bs.push_back(b);
      vec_rs1.push_back(r1);
      vec_rs2.push_back(r2);
      vec_exp.push_back(e);
   endtask

   // Drive one request for a single cycle and queue its result
   task automatic issue_request(input string name, input aes32_op_e o, input logic [1:0] b,
                                input logic [31:0] r1, input logic [31:0] r2,
                                input logic [31:0] e);
      op_valid <= 1'b1;
      op       <= o;
      bs       <= b;
      rs1      <= r1;
      rs2      <= r2;
      pend_name.push_back(name);
      pend_exp.push_back(e);
      @(posedge clk);
   endtask

   // Compare the strobed result with the oldest request
   task automatic check_result();
      string           name;
      logic [xlen-1:0] exp;
      bit              ok;
      ok = 1'b1;
      assert (pend_name.size() != 0) else begin
         $display("Result strobe seen with no request in flight");
         errors++;
      end
      if (pend_name.size() != 0) begin
         name = pend_name.pop_front();
         exp  = pend_exp.pop_front();
         assert (result === exp) else begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, result);
            ok = 1'b0;
         end
         if (ok) begin
            $display("ok       %s  %h", name, result);
            passed++;
         end else begin
            failed++;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Output monitor sampled on the falling edge
   ////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (armed && !arst_n) begin
         assert (result_valid === 1'b0 && result === '0) else begin
            $display("Outputs not cleared while reset is held");
            errors++;
         end
         prev_valid  = 1'b0;
         last_result = '0;
      end else if (armed) begin
         // Strobe must trail each request by exactly one cycle
         assert (result_valid === prev_valid) else begin
            $display("Result strobe out of step with the request strobe");
            errors++;
         end
         if (result_valid) begin
            check_result();
            last_result = result;
         end else begin
            assert (result === last_result) else begin
               $display("Result changed without a request");
               errors++;
            end
         end
         prev_valid = op_valid;
      end
   end

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] draw;
      logic [31:0] r1;
      logic [31:0] r2;
      aes32_op_e   r_op;
      logic [1:0]  r_bs;
      arst_n   = 1'b0;
      op_valid = 1'b0;
      op       = op_esi;
      bs       = '0;
      rs1      = '0;
      rs2      = '0;
      for (int i = 0; i < 256; i++) begin
         sbox_tbl[i] = sbox_rows[2047 - 8*i -: 8];
         inv_tbl[sbox_tbl[i]] = 8'(i);
      end
      load_vectors();
      limit = 4 * (vec_name.size() + n_random) + 50;

      @(posedge clk);
      armed <= 1'b1;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);

      // Directed rows with an idle cycle after each
      for (int i = 0; i < vec_name.size(); i++) begin
         issue_request(vec_name[i], vec_op[i], vec_bs[i], vec_rs1[i], vec_rs2[i], vec_exp[i]);
         // Operands change while idle so the held result is exercised
         op_valid <= 1'b0;
         rs1      <= ~vec_rs1[i];
         @(posedge clk);
      end

      // Random cases back to back
      for (int i = 0; i < n_random; i++) begin
         draw = $random(seed);
         r_op = aes32_op_e'(draw[1:0]);
         r_bs = draw[3:2];
         r1   = $random(seed);
         r2   = $random(seed);
         issue_request($sformatf("random_%0d", i), r_op, r_bs, r1, r2,
                       model_result(r_op, r_bs, r1, r2));
      end
      op_valid <= 1'b0;
      rs1      <= ~r1;

      while (pend_name.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);

      $display("Summary: %0d tests, %0d passed, %0d failed, %0d other errors",
               passed + failed, passed, failed, errors);
      if (failed == 0 && errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Run limit scales with the number of requests
   initial begin
      wait (limit != 0);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
   end

endmodule

// ==== aes32_unit.f ====
+incdir+test
common/aes_pkg.sv
common/zkn_pkg.sv
aes/aes_sbox.sv
aes/aes_inv_sbox.sv
aes/mixword.sv
aes/inv_mixword.sv
aes/aes32_round.sv
design/aes32_unit.sv
test/aes32_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AES32 unit testbench with Verilator.
# Exit status is non-zero when the log reports a failure.

set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
rm -f "$LOG"

verilator --binary --timing --assert \
   -f aes32_unit.f \
   --top-module aes32_unit_tb \
   -o aes32_unit_sim

./obj_dir/aes32_unit_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi

echo "Simulation finished without failures"
